//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "sim: pass line missing in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- cacheline_adapter.sv
module cacheline_adapter (
    input  logic                            clk,
    input  logic                            rst,

    output logic [fetch_pkg::XLEN-1:0]      bmem_addr_o,
    output logic                            bmem_read_o,
    input  logic                            bmem_ready_i,
    input  logic [fetch_pkg::BEAT_BITS-1:0] bmem_rdata_i,
    input  logic                            bmem_rvalid_i,

    line_fill_if.adapter                    fill
);

    logic                                          pending_q;   // request waiting for bmem_ready_i
    logic                                          busy_q;      // beats still coming back
    logic [$clog2(fetch_pkg::BEATS_PER_LINE)-1:0] beat_cnt_q;
    logic                                          last_beat;
    logic                                          fill_valid_q;
    logic [fetch_pkg::XLEN-1:0]                    addr_q;
    fetch_pkg::line_t                              line_q;

    // memory only sees the read while it is ready
    assign bmem_read_o = pending_q && bmem_ready_i;
    assign bmem_addr_o = addr_q;

    assign last_beat = (beat_cnt_q == $bits(beat_cnt_q)'(fetch_pkg::BEATS_PER_LINE - 1));

    assign fill.fill_valid = fill_valid_q;
    assign fill.line       = line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q    <= 1'b0;
            busy_q       <= 1'b0;
            beat_cnt_q   <= '0;
            fill_valid_q <= 1'b0;
        end else begin
            fill_valid_q <= 1'b0;

            if (fill.fill_req) begin
                pending_q <= 1'b1;
            end else if (bmem_read_o) begin
                pending_q <= 1'b0;
                busy_q    <= 1'b1;
            end

            if (busy_q && bmem_rvalid_i) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;  // wraps back to beat 0
                if (last_beat) begin
                    busy_q       <= 1'b0;
                    fill_valid_q <= 1'b1;
                end
            end
        end
    end

    // address and assembled line
    always_ff @(posedge clk) begin
        if (fill.fill_req) begin
            addr_q <= fill.fill_addr;
        end
        if (busy_q && bmem_rvalid_i) begin
            line_q.beats[beat_cnt_q] <= bmem_rdata_i;  // lowest beat first
        end
    end

endmodule

//--- fetch_checker.sv
module fetch_checker #(
    parameter logic [31:0] INST_SALT = '0
) (
    input logic                            clk,
    input logic                            rst,
    input logic [fetch_pkg::XLEN-1:0]      bmem_addr_i,
    input logic                            bmem_read_i,
    input logic                            bmem_ready_i,
    input logic                            bmem_rvalid_i,
    input logic                            redirect_i,
    input logic [fetch_pkg::XLEN-1:0]      redirect_pc_i,
    input logic                            deq_i,
    input logic                            inst_valid_i,
    input logic [fetch_pkg::XLEN-1:0]      inst_i,
    input logic [fetch_pkg::XLEN-1:0]      inst_pc_i
);

    int fail_cnt = 0;  // watched by the testbench top

    logic [fetch_pkg::XLEN-1:0]        exp_pc;      // next pc the consumer should see
    logic [2:0]                        beats_left;
    logic [fetch_pkg::CACHE_LINES-1:0] line_seen;
    logic [fetch_pkg::XLEN-1:0]        line_addr [fetch_pkg::CACHE_LINES];
    logic [fetch_pkg::INDEX_BITS-1:0]  read_idx;

    assign read_idx = bmem_addr_i[fetch_pkg::OFFSET_BITS +: fetch_pkg::INDEX_BITS];

    always_ff @(posedge clk) begin
        if (rst) begin
            exp_pc     <= fetch_pkg::RESET_PC;
            beats_left <= 3'd0;
            line_seen  <= '0;
        end else begin
            if (redirect_i) begin
                exp_pc <= redirect_pc_i;
            end else if (deq_i && inst_valid_i) begin
                exp_pc <= inst_pc_i + 32'd4;
            end

            if (bmem_read_i) begin
                beats_left          <= 3'd4;
                line_seen[read_idx] <= 1'b1;
                line_addr[read_idx] <= bmem_addr_i;  // mirrors the cache tag store
            end else if (bmem_rvalid_i && beats_left != 3'd0) begin
                beats_left <= beats_left - 3'd1;
            end
        end
    end

    reset_quiet: assert property (@(posedge clk) rst |=> !inst_valid_i && !bmem_read_i)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("FAIL %0t: output active in reset", $time);
        end

    inst_content: assert property (@(posedge clk) disable iff (rst)
        inst_valid_i |-> inst_i == (inst_pc_i ^ INST_SALT))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("FAIL %0t: wrong inst_o", $time);
        end

    pc_order: assert property (@(posedge clk) disable iff (rst)
        deq_i && inst_valid_i |-> inst_pc_i == exp_pc)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("FAIL %0t: wrong inst_pc_o", $time);
        end

    burst_request: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> bmem_addr_i[fetch_pkg::OFFSET_BITS-1:0] == '0 && bmem_ready_i)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("FAIL %0t: bad burst request", $time);
        end

    burst_overlap: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> beats_left == 3'd0)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("FAIL %0t: burst overlap", $time);
        end

    // a resident line is never fetched again
    no_refetch: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> !(line_seen[read_idx] && line_addr[read_idx] == bmem_addr_i))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("FAIL %0t: refetch of cached line", $time);
        end

endmodule

//--- fetch_if.sv
// word fetch between pc_sequencer and icache
interface fetch_req_if;

    logic                      req;   // one-cycle pulse
    logic [fetch_pkg::XLEN-1:0] addr;  // word aligned
    logic                      resp;  // one-cycle pulse
    logic [fetch_pkg::XLEN-1:0] word;

    modport sequencer (
        output req,
        output addr,
        input  resp,
        input  word
    );

    modport cache (
        input  req,
        input  addr,
        output resp,
        output word
    );

endinterface

// line refill between icache and cacheline_adapter
interface line_fill_if;

    logic                       fill_req;    // one-cycle pulse
    logic [fetch_pkg::XLEN-1:0] fill_addr;   // line aligned
    logic                       fill_valid;  // one-cycle pulse, line is complete
    fetch_pkg::line_t           line;

    modport cache (
        output fill_req,
        output fill_addr,
        input  fill_valid,
        input  line
    );

    modport adapter (
        input  fill_req,
        input  fill_addr,
        output fill_valid,
        output line
    );

endinterface

//--- fetch_pkg.sv
package fetch_pkg;

    // instruction, word and address width
    localparam int XLEN = 32;

    localparam logic [XLEN-1:0] RESET_PC = 32'h1eceb000;

    // burst memory side
    localparam int BEAT_BITS      = 64;
    localparam int BEATS_PER_LINE = 4;

    // cache geometry
    localparam int LINE_BYTES  = 32;
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int CACHE_LINES = 8;
    localparam int INDEX_BITS  = $clog2(CACHE_LINES);
    localparam int TAG_BITS    = XLEN - INDEX_BITS - OFFSET_BITS;

    localparam int QUEUE_DEPTH = 8;   // instruction queue entries

    // one cache line, seen as fetch words or as memory beats
    typedef union packed {
        logic [LINE_BYTES/4-1:0][XLEN-1:0]        words;  // read by icache
        logic [BEATS_PER_LINE-1:0][BEAT_BITS-1:0] beats;  // filled by the adapter
    } line_t;

endpackage

//--- fetch_top.sv
module fetch_top (
    input  logic                            clk,
    input  logic                            rst,

    // burst memory
    output logic [fetch_pkg::XLEN-1:0]      bmem_addr_o,
    output logic                            bmem_read_o,
    input  logic                            bmem_ready_i,
    input  logic [fetch_pkg::BEAT_BITS-1:0] bmem_rdata_i,
    input  logic                            bmem_rvalid_i,

    // branch redirect
    input  logic                            redirect_i,
    input  logic [fetch_pkg::XLEN-1:0]      redirect_pc_i,

    // instruction consumer
    input  logic                            deq_i,
    output logic                            inst_valid_o,
    output logic [fetch_pkg::XLEN-1:0]      inst_o,
    output logic [fetch_pkg::XLEN-1:0]      inst_pc_o
);

    fetch_req_if fetch_bus ();
    line_fill_if fill_bus ();

    logic                       queue_full;
    logic                       push;
    logic [fetch_pkg::XLEN-1:0] push_inst;
    logic [fetch_pkg::XLEN-1:0] push_pc;

    pc_sequencer pc_sequencer_i (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .queue_full_i  (queue_full),
        .push_o        (push),
        .push_inst_o   (push_inst),
        .push_pc_o     (push_pc),
        .fetch         (fetch_bus.sequencer)
    );

    icache icache_i (
        .clk   (clk),
        .rst   (rst),
        .fetch (fetch_bus.cache),
        .fill  (fill_bus.cache)
    );

    cacheline_adapter cacheline_adapter_i (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .fill          (fill_bus.adapter)
    );

    inst_queue inst_queue_i (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (redirect_i),  // queue empties on redirect
        .push_i      (push),
        .push_inst_i (push_inst),
        .push_pc_i   (push_pc),
        .pop_i       (deq_i),
        .full_o      (queue_full),
        .valid_o     (inst_valid_o),
        .inst_o      (inst_o),
        .pc_o        (inst_pc_o)
    );

endmodule

//--- icache.sv
module icache (
    input  logic        clk,
    input  logic        rst,

    fetch_req_if.cache  fetch,
    line_fill_if.cache  fill
);

    logic [fetch_pkg::CACHE_LINES-1:0] valid_q;
    logic [fetch_pkg::TAG_BITS-1:0]    tag_q  [fetch_pkg::CACHE_LINES];
    fetch_pkg::line_t                  data_q [fetch_pkg::CACHE_LINES];

    logic                              miss_q;       // waiting on a refill
    logic [fetch_pkg::XLEN-1:0]        miss_addr_q;
    logic                              fill_req_q;
    logic                              resp_q;
    logic [fetch_pkg::XLEN-1:0]        word_q;

    // fields of the incoming request
    logic [fetch_pkg::TAG_BITS-1:0]    req_tag;
    logic [fetch_pkg::INDEX_BITS-1:0]  req_idx;
    logic [fetch_pkg::OFFSET_BITS-3:0] req_off;
    logic                              hit;

    // fields of the missed address
    logic [fetch_pkg::TAG_BITS-1:0]    miss_tag;
    logic [fetch_pkg::INDEX_BITS-1:0]  miss_idx;
    logic [fetch_pkg::OFFSET_BITS-3:0] miss_off;
    logic                              refill;

    assign req_tag = fetch.addr[fetch_pkg::XLEN-1 -: fetch_pkg::TAG_BITS];
    assign req_idx = fetch.addr[fetch_pkg::OFFSET_BITS +: fetch_pkg::INDEX_BITS];
    assign req_off = fetch.addr[fetch_pkg::OFFSET_BITS-1:2];

    assign miss_tag = miss_addr_q[fetch_pkg::XLEN-1 -: fetch_pkg::TAG_BITS];
    assign miss_idx = miss_addr_q[fetch_pkg::OFFSET_BITS +: fetch_pkg::INDEX_BITS];
    assign miss_off = miss_addr_q[fetch_pkg::OFFSET_BITS-1:2];

    assign hit    = valid_q[req_idx] && (tag_q[req_idx] == req_tag);
    assign refill = miss_q && fill.fill_valid;

    assign fetch.resp = resp_q;
    assign fetch.word = word_q;

    assign fill.fill_req  = fill_req_q;
    assign fill.fill_addr = {miss_addr_q[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_BITS],
                             {fetch_pkg::OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q    <= '0;
            miss_q     <= 1'b0;
            fill_req_q <= 1'b0;
            resp_q     <= 1'b0;
        end else begin
            fill_req_q <= 1'b0;
            resp_q     <= 1'b0;

            if (fetch.req) begin
                if (hit) begin
                    resp_q <= 1'b1;
                end else begin
                    miss_q     <= 1'b1;
                    fill_req_q <= 1'b1;
                end
            end

            // answer the missed word once the line is in
            if (refill) begin
                valid_q[miss_idx] <= 1'b1;
                miss_q            <= 1'b0;
                resp_q            <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch.req) begin
            word_q <= data_q[req_idx].words[req_off];
            if (!hit) begin
                miss_addr_q <= fetch.addr;
            end
        end
        if (refill) begin
            tag_q[miss_idx]  <= miss_tag;
            data_q[miss_idx] <= fill.line;
            word_q           <= fill.line.words[miss_off];
        end
    end

endmodule

//--- inst_queue.sv
module inst_queue (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        flush_i,
    input  logic                        push_i,
    input  logic [fetch_pkg::XLEN-1:0]  push_inst_i,
    input  logic [fetch_pkg::XLEN-1:0]  push_pc_i,
    input  logic                        pop_i,

    output logic                        full_o,
    output logic                        valid_o,
    output logic [fetch_pkg::XLEN-1:0]  inst_o,
    output logic [fetch_pkg::XLEN-1:0]  pc_o
);

    logic [fetch_pkg::XLEN-1:0] inst_mem [fetch_pkg::QUEUE_DEPTH];
    logic [fetch_pkg::XLEN-1:0] pc_mem   [fetch_pkg::QUEUE_DEPTH];

    logic [$clog2(fetch_pkg::QUEUE_DEPTH)-1:0] rd_ptr_q;
    logic [$clog2(fetch_pkg::QUEUE_DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(fetch_pkg::QUEUE_DEPTH+1)-1:0] count_q;

    logic do_push;
    logic do_pop;

    assign full_o  = (count_q == $bits(count_q)'(fetch_pkg::QUEUE_DEPTH));
    assign valid_o = (count_q != '0);
    assign inst_o  = inst_mem[rd_ptr_q];  // head of queue
    assign pc_o    = pc_mem[rd_ptr_q];

    assign do_push = push_i && !full_o;   // push while full is dropped
    assign do_pop  = pop_i && valid_o;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end

            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            inst_mem[wr_ptr_q] <= push_inst_i;
            pc_mem[wr_ptr_q]   <= push_pc_i;
        end
    end

endmodule

//--- pc_sequencer.sv
module pc_sequencer (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        redirect_i,
    input  logic [fetch_pkg::XLEN-1:0]  redirect_pc_i,
    input  logic                        queue_full_i,

    output logic                        push_o,
    output logic [fetch_pkg::XLEN-1:0]  push_inst_o,
    output logic [fetch_pkg::XLEN-1:0]  push_pc_o,

    fetch_req_if.sequencer              fetch
);

    logic [fetch_pkg::XLEN-1:0] pc_q;
    logic                       run_q;          // low in the first cycle out of reset
    logic                       outstanding_q;
    logic                       discard_q;      // in-flight response is stale

    // one request at a time, held back while the queue is full
    assign fetch.req  = run_q && !outstanding_q && !queue_full_i && !redirect_i;
    assign fetch.addr = pc_q;

    // a redirect in the same cycle flushes the queue anyway
    assign push_o      = fetch.resp && !discard_q && !redirect_i;
    assign push_inst_o = fetch.word;
    assign push_pc_o   = pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q          <= fetch_pkg::RESET_PC;
            run_q         <= 1'b0;
            outstanding_q <= 1'b0;
            discard_q     <= 1'b0;
        end else begin
            run_q <= 1'b1;

            if (fetch.req) begin
                outstanding_q <= 1'b1;
            end else if (fetch.resp) begin
                outstanding_q <= 1'b0;
            end

            // drop whatever is still on its way
            if (redirect_i && outstanding_q && !fetch.resp) begin
                discard_q <= 1'b1;
            end else if (fetch.resp) begin
                discard_q <= 1'b0;
            end

            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (push_o) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

endmodule

//--- src.f
fetch_pkg.sv
fetch_if.sv
cacheline_adapter.sv
icache.sv
pc_sequencer.sv
inst_queue.sv
fetch_top.sv
fetch_checker.sv
tb_clock_gen.sv
tb_fetch.sv

//--- tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD = 20
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

//--- tb_fetch.sv
module tb_fetch;

    localparam logic [31:0] INST_SALT    = 32'h5a3c96e1;
    localparam int          SEED         = 24028;
    localparam int          RESET_CYCLES = 16;
    localparam int          TARGET_DEQS  = 1500;
    localparam int          MAX_CYCLES   = TARGET_DEQS * 20;  // ~3 cycles per inst expected

    logic        clk;
    logic        rst         = 1'b1;
    logic        bmem_ready  = 1'b0;
    logic [63:0] bmem_rdata  = '0;
    logic        bmem_rvalid = 1'b0;
    logic        redirect    = 1'b0;
    logic [31:0] redirect_pc = '0;
    logic        deq         = 1'b0;
    logic [31:0] bmem_addr;
    logic        bmem_read;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] inst_pc;

    logic        mem_busy = 1'b0;  // burst in progress
    logic [31:0] mem_line;
    int          beat_idx = 0;
    int          gap = 0;          // idle cycles before the next beat
    int          cycle_cnt = 0;
    int          deq_cnt = 0;
    int          next_redirect = 150;

    tb_clock_gen #(.PERIOD(20)) clock_gen (.clk_o(clk));

    fetch_top dut (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .deq_i         (deq),
        .inst_valid_o  (inst_valid),
        .inst_o        (inst),
        .inst_pc_o     (inst_pc)
    );

    // same salt as INST_SALT above
    bind fetch_top fetch_checker #(.INST_SALT(32'h5a3c96e1)) checker_i (
        .clk (clk), .rst (rst),
        .bmem_addr_i (bmem_addr_o), .bmem_read_i (bmem_read_o),
        .bmem_ready_i (bmem_ready_i), .bmem_rvalid_i (bmem_rvalid_i),
        .redirect_i (redirect_i), .redirect_pc_i (redirect_pc_i),
        .deq_i (deq_i), .inst_valid_i (inst_valid_o),
        .inst_i (inst_o), .inst_pc_i (inst_pc_o)
    );

    // two words per beat, lower address in the low half
    function automatic logic [63:0] memory_beat(logic [31:0] line_addr, int beat);
        logic [31:0] lo_addr;
        lo_addr = line_addr + 32'(8 * beat);
        return {(lo_addr + 32'd4) ^ INST_SALT, lo_addr ^ INST_SALT};
    endfunction

    // word address in a 512-byte window around the reset vector
    function automatic logic [31:0] redirect_target();
        return fetch_pkg::RESET_PC - 32'd256 + 32'(4 * $urandom_range(127));
    endfunction

    initial begin
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

    // burst memory model
    always @(posedge clk) begin
        if (rst) begin
            bmem_ready  <= 1'b0;
            bmem_rvalid <= 1'b0;
            mem_busy    <= 1'b0;
        end else begin
            bmem_ready  <= ($urandom_range(3) != 0);
            bmem_rvalid <= 1'b0;
            if (bmem_read) begin
                mem_busy <= 1'b1;
                mem_line <= bmem_addr;
                beat_idx <= 0;
                gap      <= $urandom_range(3);
            end else if (mem_busy) begin
                if (gap > 0) begin
                    gap <= gap - 1;
                end else begin
                    bmem_rvalid <= 1'b1;
                    bmem_rdata  <= memory_beat(mem_line, beat_idx);
                    beat_idx    <= beat_idx + 1;
                    gap         <= $urandom_range(3);
                    mem_busy    <= (beat_idx < 3);  // last beat ends the burst
                end
            end
        end
    end

    // consumer and branch redirects
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (rst) begin
            deq      <= 1'b0;
            redirect <= 1'b0;
        end else begin
            deq      <= 1'($urandom_range(1));
            redirect <= 1'b0;
            if (deq && inst_valid) begin
                deq_cnt <= deq_cnt + 1;
            end
            if (cycle_cnt >= next_redirect) begin
                redirect      <= 1'b1;
                redirect_pc   <= redirect_target();
                next_redirect <= cycle_cnt + 100 + $urandom_range(100);
            end
        end
    end

    always @(posedge clk) begin
        if (dut.checker_i.fail_cnt != 0) begin
            $display("Verification failed");
            $fatal(1, "assertion failure in fetch_checker");
        end else if (deq_cnt >= TARGET_DEQS) begin
            $display("Verification passed");
            $finish;
        end else if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: %0d of %0d instructions dequeued", deq_cnt, TARGET_DEQS);
            $display("Verification failed");
            $fatal(1, "run stopped at %0d cycles", cycle_cnt);
        end
    end

endmodule
